//--- rtl/xbar_cfg_pkg.sv
package xbar_cfg_pkg;

  // Number of initiator and target ports on the crossbar
  localparam int unsigned NumInit  = 2;
  localparam int unsigned NumTgt   = 2;
  // Number of entries in the fixed address map
  localparam int unsigned NumRules = 3;

  // Widths of the request and response fields
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 2;

  // Width of an initiator index as it is appended to a target-side ID
  localparam int unsigned InitIdxWidth = (NumInit > 1) ? $clog2(NumInit) : 1;
  // Target-side ID carries the initiator index in its top bits
  localparam int unsigned TgtIdWidth   = IdWidth + InitIdxWidth;
  // Width of a target port index
  localparam int unsigned TgtIdxWidth  = (NumTgt > 1) ? $clog2(NumTgt) : 1;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [TgtIdWidth-1:0]   tgt_id_t;
  typedef logic [TgtIdxWidth-1:0]  tgt_idx_t;
  typedef logic [InitIdxWidth-1:0] init_idx_t;

  // Address map with the start included and the end excluded
  // Where ranges overlap the rule with the higher index decides
  localparam addr_t RuleStart [NumRules] = '{16'h0000, 16'h4000, 16'h3000};
  localparam addr_t RuleEnd   [NumRules] = '{16'h4000, 16'h8000, 16'h5000};
  // Target port that each rule selects
  localparam tgt_idx_t RuleTgt [NumRules] = '{1'b0, 1'b1, 1'b1};

endpackage

//--- rtl/xbar_resp_pkg.sv
package xbar_resp_pkg;

  // Read response codes keep their AXI encodings
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  // Data word that the decode-error responder returns
  localparam logic [31:0] DecErrData = 32'hBADCAB1E;

endpackage

//--- rtl/xbar_addr_decode.sv
`timescale 1ns/100ps

module xbar_addr_decode (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                   [xbar_cfg_pkg::NumInit-1:0]    req_valid_i,
  input  xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumInit-1:0]    req_addr_i,
  input  xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0]    req_id_i,
  input  logic                   [xbar_cfg_pkg::NumInit-1:0]    def_en_i,
  input  xbar_cfg_pkg::tgt_idx_t [xbar_cfg_pkg::NumInit-1:0]    def_tgt_i,
  output logic                   [xbar_cfg_pkg::NumInit-1:0]    dec_valid_o,
  output xbar_cfg_pkg::tgt_idx_t [xbar_cfg_pkg::NumInit-1:0]    dec_tgt_o,
  output logic                   [xbar_cfg_pkg::NumInit-1:0]    err_valid_o,
  output xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0]    err_id_o,
  output xbar_cfg_pkg::data_t    [xbar_cfg_pkg::NumInit-1:0]    err_data_o,
  output xbar_resp_pkg::resp_e   [xbar_cfg_pkg::NumInit-1:0]    err_code_o
);

  // Result of the rule lookup per initiator
  logic                   [xbar_cfg_pkg::NumInit-1:0] rule_hit;
  xbar_cfg_pkg::tgt_idx_t [xbar_cfg_pkg::NumInit-1:0] rule_tgt;

  // Pending decode-error response, one per initiator
  logic                   [xbar_cfg_pkg::NumInit-1:0] err_valid_q;
  xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0] err_id_q;

  // Walk the rules in ascending order so that a later match overrides an earlier one
  always_comb begin
    for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
      rule_hit[i] = 1'b0;
      rule_tgt[i] = '0;
      for (int r = 0; r < xbar_cfg_pkg::NumRules; r++) begin
        if (req_addr_i[i] >= xbar_cfg_pkg::RuleStart[r] &&
            req_addr_i[i] <  xbar_cfg_pkg::RuleEnd[r]) begin
          rule_hit[i] = 1'b1;
          rule_tgt[i] = xbar_cfg_pkg::RuleTgt[r];
        end
      end
    end
  end

  // A request goes to the arbiter if a rule matched or the default target is on
  always_comb begin
    for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
      dec_valid_o[i] = req_valid_i[i] & (rule_hit[i] | def_en_i[i]);
      dec_tgt_o[i]   = rule_hit[i] ? rule_tgt[i] : def_tgt_i[i];
    end
  end

  // Unmapped requests without a default are answered here one cycle later
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_valid_q <= '0;
    end else begin
      err_valid_q <= req_valid_i & ~rule_hit & ~def_en_i;
    end
  end

  // The ID is echoed back unchanged in the error response
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
      if (req_valid_i[i]) begin
        err_id_q[i] <= req_id_i[i];
      end
    end
  end

  assign err_valid_o = err_valid_q;
  assign err_id_o    = err_id_q;

  for (genvar i = 0; i < xbar_cfg_pkg::NumInit; i++) begin : gen_err_rsp
    assign err_data_o[i] = xbar_cfg_pkg::data_t'(xbar_resp_pkg::DecErrData);
    assign err_code_o[i] = xbar_resp_pkg::RESP_DECERR;

    // Default routing must hold still while a request on this port is decoded and issued
    a_def_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i[i] |=> $stable(def_en_i[i]) && $stable(def_tgt_i[i]))
      else $error("default target changed under a request on initiator %0d", i);
  end

endmodule

//--- rtl/xbar_req_arbiter.sv
`timescale 1ns/100ps

module xbar_req_arbiter (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic                   [xbar_cfg_pkg::NumInit-1:0]  dec_valid_i,
  input  xbar_cfg_pkg::tgt_idx_t [xbar_cfg_pkg::NumInit-1:0]  dec_tgt_i,
  input  xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumInit-1:0]  req_addr_i,
  input  xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0]  req_id_i,
  output logic                   [xbar_cfg_pkg::NumTgt-1:0]   tgt_req_valid_o,
  output xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumTgt-1:0]   tgt_req_addr_o,
  output xbar_cfg_pkg::tgt_id_t  [xbar_cfg_pkg::NumTgt-1:0]   tgt_req_id_o
);

  // Hold register per initiator for a request that lost arbitration
  logic                    [xbar_cfg_pkg::NumInit-1:0] hold_valid_q;
  xbar_cfg_pkg::tgt_idx_t  [xbar_cfg_pkg::NumInit-1:0] hold_tgt_q;
  xbar_cfg_pkg::addr_t     [xbar_cfg_pkg::NumInit-1:0] hold_addr_q;
  xbar_cfg_pkg::id_t       [xbar_cfg_pkg::NumInit-1:0] hold_id_q;

  // Request that each initiator presents this cycle
  logic                    [xbar_cfg_pkg::NumInit-1:0] cand_valid;
  xbar_cfg_pkg::tgt_idx_t  [xbar_cfg_pkg::NumInit-1:0] cand_tgt;
  xbar_cfg_pkg::addr_t     [xbar_cfg_pkg::NumInit-1:0] cand_addr;
  xbar_cfg_pkg::id_t       [xbar_cfg_pkg::NumInit-1:0] cand_id;

  // Arbitration state and outcome per target
  xbar_cfg_pkg::init_idx_t [xbar_cfg_pkg::NumTgt-1:0]  rr_q;
  logic                    [xbar_cfg_pkg::NumTgt-1:0]  gnt_valid;
  xbar_cfg_pkg::init_idx_t [xbar_cfg_pkg::NumTgt-1:0]  gnt_idx;
  logic                    [xbar_cfg_pkg::NumInit-1:0] granted;

  // Registered target ports
  logic                    [xbar_cfg_pkg::NumTgt-1:0]  tgt_req_valid_q;
  xbar_cfg_pkg::addr_t     [xbar_cfg_pkg::NumTgt-1:0]  tgt_req_addr_q;
  xbar_cfg_pkg::tgt_id_t   [xbar_cfg_pkg::NumTgt-1:0]  tgt_req_id_q;

  // A held request replaces the live input since only one read is in flight per initiator
  always_comb begin
    for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
      cand_valid[i] = hold_valid_q[i] | dec_valid_i[i];
      cand_tgt[i]   = hold_valid_q[i] ? hold_tgt_q[i]  : dec_tgt_i[i];
      cand_addr[i]  = hold_valid_q[i] ? hold_addr_q[i] : req_addr_i[i];
      cand_id[i]    = hold_valid_q[i] ? hold_id_q[i]   : req_id_i[i];
    end
  end

  always_comb begin
    int idx;
    gnt_valid = '0;
    gnt_idx   = '0;
    granted   = '0;
    for (int t = 0; t < xbar_cfg_pkg::NumTgt; t++) begin
      // Held requests go first, so none of them waits longer than one extra cycle
      for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
        if (!gnt_valid[t] && hold_valid_q[i] &&
            hold_tgt_q[i] == xbar_cfg_pkg::tgt_idx_t'(t)) begin
          gnt_valid[t] = 1'b1;
          gnt_idx[t]   = xbar_cfg_pkg::init_idx_t'(i);
        end
      end
      // Otherwise scan the initiators starting at the round-robin pointer
      for (int k = 0; k < xbar_cfg_pkg::NumInit; k++) begin
        idx = (int'(rr_q[t]) + k) % int'(xbar_cfg_pkg::NumInit);
        if (!gnt_valid[t] && cand_valid[idx] &&
            cand_tgt[idx] == xbar_cfg_pkg::tgt_idx_t'(t)) begin
          gnt_valid[t] = 1'b1;
          gnt_idx[t]   = xbar_cfg_pkg::init_idx_t'(idx);
        end
      end
      if (gnt_valid[t]) begin
        granted[gnt_idx[t]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tgt_req_valid_q <= '0;
      hold_valid_q    <= '0;
      rr_q            <= '0;
    end else begin
      tgt_req_valid_q <= gnt_valid;
      // Every request that was not granted waits in its hold register
      hold_valid_q    <= cand_valid & ~granted;
      for (int t = 0; t < xbar_cfg_pkg::NumTgt; t++) begin
        if (gnt_valid[t]) begin
          rr_q[t] <= xbar_cfg_pkg::init_idx_t'((int'(gnt_idx[t]) + 1) %
                                                int'(xbar_cfg_pkg::NumInit));
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int t = 0; t < xbar_cfg_pkg::NumTgt; t++) begin
      if (gnt_valid[t]) begin
        tgt_req_addr_q[t] <= cand_addr[gnt_idx[t]];
        // Initiator index goes on top so the response can find its way back
        tgt_req_id_q[t]   <= {gnt_idx[t], cand_id[gnt_idx[t]]};
      end
    end
    for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
      if (cand_valid[i]) begin
        hold_tgt_q[i]  <= cand_tgt[i];
        hold_addr_q[i] <= cand_addr[i];
        hold_id_q[i]   <= cand_id[i];
      end
    end
  end

  assign tgt_req_valid_o = tgt_req_valid_q;
  assign tgt_req_addr_o  = tgt_req_addr_q;
  assign tgt_req_id_o    = tgt_req_id_q;

  for (genvar i = 0; i < xbar_cfg_pkg::NumInit; i++) begin : gen_hold_check
    // A held request is always issued on the following cycle
    a_hold_once: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      hold_valid_q[i] |=> !hold_valid_q[i])
      else $error("hold register of initiator %0d issued twice in a row", i);
  end

endmodule

//--- rtl/xbar_resp_router.sv
`timescale 1ns/100ps

module xbar_resp_router (
  input  logic                  [xbar_cfg_pkg::NumTgt-1:0]  tgt_rsp_valid_i,
  input  xbar_cfg_pkg::tgt_id_t [xbar_cfg_pkg::NumTgt-1:0]  tgt_rsp_id_i,
  input  xbar_cfg_pkg::data_t   [xbar_cfg_pkg::NumTgt-1:0]  tgt_rsp_data_i,
  input  xbar_resp_pkg::resp_e  [xbar_cfg_pkg::NumTgt-1:0]  tgt_rsp_code_i,
  input  logic                  [xbar_cfg_pkg::NumInit-1:0] err_valid_i,
  input  xbar_cfg_pkg::id_t     [xbar_cfg_pkg::NumInit-1:0] err_id_i,
  input  xbar_cfg_pkg::data_t   [xbar_cfg_pkg::NumInit-1:0] err_data_i,
  input  xbar_resp_pkg::resp_e  [xbar_cfg_pkg::NumInit-1:0] err_code_i,
  output logic                  [xbar_cfg_pkg::NumInit-1:0] rsp_valid_o,
  output xbar_cfg_pkg::id_t     [xbar_cfg_pkg::NumInit-1:0] rsp_id_o,
  output xbar_cfg_pkg::data_t   [xbar_cfg_pkg::NumInit-1:0] rsp_data_o,
  output xbar_resp_pkg::resp_e  [xbar_cfg_pkg::NumInit-1:0] rsp_code_o
);

  // Initiator that each target response belongs to
  xbar_cfg_pkg::init_idx_t [xbar_cfg_pkg::NumTgt-1:0] rsp_owner;
  // Per initiator one bit per target plus the top bit for its own error responder
  logic [xbar_cfg_pkg::NumInit-1:0][xbar_cfg_pkg::NumTgt:0] src_hit;

  always_comb begin
    for (int t = 0; t < xbar_cfg_pkg::NumTgt; t++) begin
      rsp_owner[t] = tgt_rsp_id_i[t][xbar_cfg_pkg::TgtIdWidth-1 -: xbar_cfg_pkg::InitIdxWidth];
    end
    for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
      src_hit[i][xbar_cfg_pkg::NumTgt] = err_valid_i[i];
      for (int t = 0; t < xbar_cfg_pkg::NumTgt; t++) begin
        src_hit[i][t] = tgt_rsp_valid_i[t] && rsp_owner[t] == xbar_cfg_pkg::init_idx_t'(i);
      end
    end
  end

  // Error payload is the fallback and a target response overrides it
  always_comb begin
    for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
      rsp_valid_o[i] = |src_hit[i];
      rsp_id_o[i]    = err_id_i[i];
      rsp_data_o[i]  = err_data_i[i];
      rsp_code_o[i]  = err_code_i[i];
      for (int t = 0; t < xbar_cfg_pkg::NumTgt; t++) begin
        if (src_hit[i][t]) begin
          // Drop the initiator index to restore the original ID
          rsp_id_o[i]   = tgt_rsp_id_i[t][xbar_cfg_pkg::IdWidth-1:0];
          rsp_data_o[i] = tgt_rsp_data_i[t];
          rsp_code_o[i] = tgt_rsp_code_i[t];
        end
      end
    end
  end

  for (genvar i = 0; i < xbar_cfg_pkg::NumInit; i++) begin : gen_rsp_check
    // With one read in flight per initiator two sources can never answer together
    always_comb begin
      a_one_rsp: assert final ($onehot0(src_hit[i]))
        else $error("several responses for initiator %0d in one cycle", i);
    end
  end

endmodule

//--- rtl/rd_xbar.sv
`timescale 1ns/100ps

module rd_xbar (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  // Initiator ports
  input  logic                   [xbar_cfg_pkg::NumInit-1:0]   req_valid_i,
  input  xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumInit-1:0]   req_addr_i,
  input  xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0]   req_id_i,
  output logic                   [xbar_cfg_pkg::NumInit-1:0]   rsp_valid_o,
  output xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0]   rsp_id_o,
  output xbar_cfg_pkg::data_t    [xbar_cfg_pkg::NumInit-1:0]   rsp_data_o,
  output xbar_resp_pkg::resp_e   [xbar_cfg_pkg::NumInit-1:0]   rsp_code_o,
  // Target ports
  output logic                   [xbar_cfg_pkg::NumTgt-1:0]    tgt_req_valid_o,
  output xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumTgt-1:0]    tgt_req_addr_o,
  output xbar_cfg_pkg::tgt_id_t  [xbar_cfg_pkg::NumTgt-1:0]    tgt_req_id_o,
  input  logic                   [xbar_cfg_pkg::NumTgt-1:0]    tgt_rsp_valid_i,
  input  xbar_cfg_pkg::tgt_id_t  [xbar_cfg_pkg::NumTgt-1:0]    tgt_rsp_id_i,
  input  xbar_cfg_pkg::data_t    [xbar_cfg_pkg::NumTgt-1:0]    tgt_rsp_data_i,
  input  xbar_resp_pkg::resp_e   [xbar_cfg_pkg::NumTgt-1:0]    tgt_rsp_code_i,
  // Default target per initiator
  input  logic                   [xbar_cfg_pkg::NumInit-1:0]   def_en_i,
  input  xbar_cfg_pkg::tgt_idx_t [xbar_cfg_pkg::NumInit-1:0]   def_tgt_i
);

  // Decoder to arbiter
  logic                   [xbar_cfg_pkg::NumInit-1:0] dec_valid;
  xbar_cfg_pkg::tgt_idx_t [xbar_cfg_pkg::NumInit-1:0] dec_tgt;
  // Decode-error responder to router
  logic                   [xbar_cfg_pkg::NumInit-1:0] err_valid;
  xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0] err_id;
  xbar_cfg_pkg::data_t    [xbar_cfg_pkg::NumInit-1:0] err_data;
  xbar_resp_pkg::resp_e   [xbar_cfg_pkg::NumInit-1:0] err_code;

  xbar_addr_decode i_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_id_i    (req_id_i),
    .def_en_i    (def_en_i),
    .def_tgt_i   (def_tgt_i),
    .dec_valid_o (dec_valid),
    .dec_tgt_o   (dec_tgt),
    .err_valid_o (err_valid),
    .err_id_o    (err_id),
    .err_data_o  (err_data),
    .err_code_o  (err_code)
  );

  xbar_req_arbiter i_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .dec_valid_i     (dec_valid),
    .dec_tgt_i       (dec_tgt),
    .req_addr_i      (req_addr_i),
    .req_id_i        (req_id_i),
    .tgt_req_valid_o (tgt_req_valid_o),
    .tgt_req_addr_o  (tgt_req_addr_o),
    .tgt_req_id_o    (tgt_req_id_o)
  );

  xbar_resp_router i_router (
    .tgt_rsp_valid_i (tgt_rsp_valid_i),
    .tgt_rsp_id_i    (tgt_rsp_id_i),
    .tgt_rsp_data_i  (tgt_rsp_data_i),
    .tgt_rsp_code_i  (tgt_rsp_code_i),
    .err_valid_i     (err_valid),
    .err_id_i        (err_id),
    .err_data_i      (err_data),
    .err_code_i      (err_code),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_id_o        (rsp_id_o),
    .rsp_data_o      (rsp_data_o),
    .rsp_code_o      (rsp_code_o)
  );

  for (genvar i = 0; i < xbar_cfg_pkg::NumInit; i++) begin : gen_outstanding_check
    // Only one read per initiator may be in flight, which the hold registers rely on
    a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i[i] |=> !req_valid_i[i] until rsp_valid_o[i])
      else $error("initiator %0d issued again before its response", i);
  end

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock with a 20 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // Reset is held low over the first three rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- bench/tb_rd_xbar.sv
`timescale 1ns/100ps

module tb_rd_xbar;

  // One line of the stimulus file split per initiator
  typedef struct packed {
    logic                   [xbar_cfg_pkg::NumInit-1:0] valid;
    xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumInit-1:0] addr;
    xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0] id;
    logic                   [xbar_cfg_pkg::NumInit-1:0] def_en;
    xbar_cfg_pkg::tgt_idx_t [xbar_cfg_pkg::NumInit-1:0] def_tgt;
    xbar_resp_pkg::resp_e   [xbar_cfg_pkg::NumInit-1:0] exp_code;
    xbar_cfg_pkg::data_t    [xbar_cfg_pkg::NumInit-1:0] exp_data;
  } round_t;

  logic clk;
  logic rst_n;

  // Initiator side
  logic                   [xbar_cfg_pkg::NumInit-1:0] req_valid = '0;
  xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumInit-1:0] req_addr  = '0;
  xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0] req_id    = '0;
  logic                   [xbar_cfg_pkg::NumInit-1:0] def_en    = '0;
  xbar_cfg_pkg::tgt_idx_t [xbar_cfg_pkg::NumInit-1:0] def_tgt   = '0;
  logic                   [xbar_cfg_pkg::NumInit-1:0] rsp_valid;
  xbar_cfg_pkg::id_t      [xbar_cfg_pkg::NumInit-1:0] rsp_id;
  xbar_cfg_pkg::data_t    [xbar_cfg_pkg::NumInit-1:0] rsp_data;
  xbar_resp_pkg::resp_e   [xbar_cfg_pkg::NumInit-1:0] rsp_code;

  // Target side with a two-stage pipeline that stands in for the target latency
  logic                   [xbar_cfg_pkg::NumTgt-1:0]  tgt_req_valid;
  xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumTgt-1:0]  tgt_req_addr;
  xbar_cfg_pkg::tgt_id_t  [xbar_cfg_pkg::NumTgt-1:0]  tgt_req_id;
  logic                   [xbar_cfg_pkg::NumTgt-1:0]  tgt_rsp_valid = '0;
  xbar_cfg_pkg::tgt_id_t  [xbar_cfg_pkg::NumTgt-1:0]  tgt_rsp_id    = '0;
  xbar_cfg_pkg::data_t    [xbar_cfg_pkg::NumTgt-1:0]  tgt_rsp_data  = '0;
  xbar_resp_pkg::resp_e   [xbar_cfg_pkg::NumTgt-1:0]  tgt_rsp_code  =
    {xbar_cfg_pkg::NumTgt{xbar_resp_pkg::RESP_OKAY}};
  logic                   [xbar_cfg_pkg::NumTgt-1:0]  pipe_valid    = '0;
  xbar_cfg_pkg::addr_t    [xbar_cfg_pkg::NumTgt-1:0]  pipe_addr     = '0;
  xbar_cfg_pkg::tgt_id_t  [xbar_cfg_pkg::NumTgt-1:0]  pipe_id       = '0;

  round_t      rounds [$];
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;
  integer      seed;

  tb_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rd_xbar dut_i (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .req_valid_i     (req_valid),
    .req_addr_i      (req_addr),
    .req_id_i        (req_id),
    .rsp_valid_o     (rsp_valid),
    .rsp_id_o        (rsp_id),
    .rsp_data_o      (rsp_data),
    .rsp_code_o      (rsp_code),
    .tgt_req_valid_o (tgt_req_valid),
    .tgt_req_addr_o  (tgt_req_addr),
    .tgt_req_id_o    (tgt_req_id),
    .tgt_rsp_valid_i (tgt_rsp_valid),
    .tgt_rsp_id_i    (tgt_rsp_id),
    .tgt_rsp_data_i  (tgt_rsp_data),
    .tgt_rsp_code_i  (tgt_rsp_code),
    .def_en_i        (def_en),
    .def_tgt_i       (def_tgt)
  );

  task automatic stop_failed(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(input xbar_cfg_pkg::data_t got, input xbar_cfg_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      stop_failed($sformatf("mismatch at %0t ns: %s data %h, expected %h",
                            $time, what, got, exp));
    end
  endtask

  task automatic check_id(input xbar_cfg_pkg::id_t got, input xbar_cfg_pkg::id_t exp,
                          input string what);
    if (got !== exp) begin
      stop_failed($sformatf("mismatch at %0t ns: %s id %h, expected %h",
                            $time, what, got, exp));
    end
  endtask

  task automatic check_code(input xbar_resp_pkg::resp_e got, input xbar_resp_pkg::resp_e exp,
                            input string what);
    if (got !== exp) begin
      stop_failed($sformatf("mismatch at %0t ns: %s code %b, expected %s",
                            $time, what, got, exp.name()));
    end
  endtask

  // Each target answers two cycles after its request with the address offset by its index
  always @(posedge clk) begin
    if (!rst_n) begin
      pipe_valid    <= '0;
      tgt_rsp_valid <= '0;
    end else begin
      pipe_valid    <= tgt_req_valid;
      pipe_addr     <= tgt_req_addr;
      pipe_id       <= tgt_req_id;
      tgt_rsp_valid <= pipe_valid;
      tgt_rsp_id    <= pipe_id;
      for (int t = 0; t < xbar_cfg_pkg::NumTgt; t++) begin
        tgt_rsp_data[t] <= xbar_cfg_pkg::data_t'(pipe_addr[t]) +
                           (xbar_cfg_pkg::data_t'(t) << 16);
        tgt_rsp_code[t] <= xbar_resp_pkg::RESP_OKAY;
      end
    end
  end

  // The watchdog is armed once the number of rounds is known
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      stop_failed($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    int          fd;
    int          n;
    int          waited;
    int unsigned gap;
    string       line;
    string       what;
    logic [31:0] col [14];
    round_t      rd;
    logic [xbar_cfg_pkg::NumInit-1:0] pending;

    seed = 32'hd38c;
    fd = $fopen("bench/rd_xbar_stimulus.txt", "r");
    if (fd == 0) begin
      stop_failed("could not open the stimulus file bench/rd_xbar_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Blank lines and comment lines carry no transaction
      if (line.len() < 4 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                  col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
      if (n != 14) begin
        stop_failed($sformatf("a stimulus line has %0d fields instead of 14", n));
      end
      for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
        rd.valid[i]    = col[3*i][0];
        rd.addr[i]     = xbar_cfg_pkg::addr_t'(col[3*i+1]);
        rd.id[i]       = xbar_cfg_pkg::id_t'(col[3*i+2]);
        rd.def_en[i]   = col[6+2*i][0];
        rd.def_tgt[i]  = xbar_cfg_pkg::tgt_idx_t'(col[7+2*i]);
        rd.exp_code[i] = xbar_resp_pkg::resp_e'(col[10+2*i][1:0]);
        rd.exp_data[i] = xbar_cfg_pkg::data_t'(col[11+2*i]);
      end
      rounds.push_back(rd);
    end
    $fclose(fd);
    if (rounds.size() == 0) begin
      stop_failed("the stimulus file holds no transactions");
    end
    cycle_limit = rounds.size() * 12;

    wait (rst_n === 1'b1);
    foreach (rounds[r]) begin
      rd = rounds[r];
      // Default routing is set up a cycle ahead so it is stable under the request
      @(posedge clk);
      def_en  <= rd.def_en;
      def_tgt <= rd.def_tgt;
      @(posedge clk);
      req_valid <= rd.valid;
      req_addr  <= rd.addr;
      req_id    <= rd.id;
      pending = rd.valid;
      waited  = 0;
      // Responses are sampled mid-cycle, where the combinational router output has settled
      while (pending != '0) begin
        @(negedge clk);
        waited++;
        for (int i = 0; i < xbar_cfg_pkg::NumInit; i++) begin
          if (rsp_valid[i]) begin
            what = $sformatf("round %0d initiator %0d", r, i);
            if (!pending[i]) begin
              stop_failed($sformatf("%s received a response it never asked for", what));
            end
            check_id(rsp_id[i], rd.id[i], what);
            check_code(rsp_code[i], rd.exp_code[i], what);
            check_data(rsp_data[i], rd.exp_data[i], what);
            // Error answers come from a register right behind the decoder
            if (rd.exp_code[i] == xbar_resp_pkg::RESP_DECERR && waited != 2) begin
              stop_failed($sformatf("%s got its decode error %0d cycles after the request",
                                    what, waited - 1));
            end
            pending[i] = 1'b0;
          end
        end
        @(posedge clk);
        req_valid <= '0;
      end
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk);
    end

    $display("Test passed");
    $finish;
  end

endmodule

//--- rd_xbar.f
rtl/xbar_cfg_pkg.sv
rtl/xbar_resp_pkg.sv
rtl/xbar_addr_decode.sv
rtl/xbar_req_arbiter.sv
rtl/xbar_resp_router.sv
rtl/rd_xbar.sv
bench/tb_clk_gen.sv
bench/tb_rd_xbar.sv

//--- Bender.yml
package:
  name: rd_xbar

sources:
  - rtl/xbar_cfg_pkg.sv
  - rtl/xbar_resp_pkg.sv
  - rtl/xbar_addr_decode.sv
  - rtl/xbar_req_arbiter.sv
  - rtl/xbar_resp_router.sv
  - rtl/rd_xbar.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_rd_xbar.sv

//--- bench/rd_xbar_stimulus.txt
# v0 addr0 id0 v1 addr1 id1 en0 deftgt0 en1 deftgt1 code0 data0 code1 data1 (all hex)
# Code 0 is OKAY and 3 is DECERR, expected fields of an idle initiator are ignored
1 2000 1 0 0000 0 0 0 0 0 0 00002000 0 00000000
1 6000 2 0 0000 0 0 0 0 0 0 00016000 0 00000000
1 3800 3 0 0000 0 0 0 0 0 0 00013800 0 00000000
0 0000 0 1 4000 0 0 0 0 0 0 00000000 0 00014000
1 3fff 2 0 0000 0 0 0 0 0 0 00013fff 0 00000000
0 0000 0 1 2fff 1 0 0 0 0 0 00000000 0 00002fff
1 3000 0 1 5000 3 0 0 0 0 0 00013000 0 00015000
1 7fff 1 0 0000 0 0 0 0 0 0 00017fff 0 00000000
1 9000 2 0 0000 0 0 0 0 0 3 badcab1e 0 00000000
0 0000 0 1 8000 1 0 0 0 0 0 00000000 3 badcab1e
1 9000 3 0 0000 0 1 0 0 0 0 00009000 0 00000000
0 0000 0 1 9000 2 0 0 1 1 0 00000000 0 00019000
1 2000 1 1 1000 2 0 0 0 0 0 00002000 0 00001000
1 6000 2 1 3800 3 0 0 0 0 0 00016000 0 00013800
1 1234 0 1 5678 1 0 0 0 0 0 00001234 0 00015678
1 7000 3 1 0100 2 0 0 0 0 0 00017000 0 00000100
1 a000 1 1 2000 0 0 0 0 0 3 badcab1e 0 00002000
1 ffff 2 1 8000 3 0 0 0 0 3 badcab1e 3 badcab1e
1 c000 0 1 d000 1 1 1 1 1 0 0001c000 0 0001d000
1 2000 3 0 0000 0 1 1 0 0 0 00002000 0 00000000
